// File: src/bus_pkg.sv
package bus_pkg;

    // cpu and memory data path
    localparam int WORD_BYTES = 8;
    localparam int WORD_BITS  = 8 * WORD_BYTES;
    localparam int ADDR_BITS  = 64;

    // memory bursts always move one full line
    localparam int BURST_LEN = 16;
    localparam int BEAT_BITS = $clog2(BURST_LEN);

    typedef logic [WORD_BITS-1:0]  word_t;
    typedef logic [WORD_BYTES-1:0] strobe_t;
    typedef logic [ADDR_BITS-1:0]  addr_t;

endpackage

// File: src/cache_pkg.sv
package cache_pkg;

    import bus_pkg::*;

    // geometry
    localparam int WAYS           = 4;
    localparam int SETS           = 4;
    localparam int WORDS_PER_LINE = 16;
    localparam int WAY_BITS       = $clog2(WAYS);
    localparam int OFFSET_BITS    = $clog2(WORDS_PER_LINE);
    localparam int INDEX_BITS     = $clog2(SETS);
    localparam int BYTE_BITS      = $clog2(WORD_BYTES);
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    // word address into line storage: set, way, word
    localparam int RAM_ADDR_BITS  = INDEX_BITS + WAY_BITS + OFFSET_BITS;

    typedef logic [WAY_BITS-1:0] way_t;
    typedef logic [WAY_BITS-1:0] age_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } meta_t;

    // one address word, seen raw or split into its cache fields
    typedef union packed {
        addr_t raw;
        struct packed {
            tag_t                   tag;
            logic [INDEX_BITS-1:0]  index;
            logic [OFFSET_BITS-1:0] offset;
            logic [BYTE_BITS-1:0]   byte_off;
        } fields;
    } cache_addr_u;

endpackage

// File: src/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     en,
    input  logic [RAM_ADDR_BITS-1:0] addr,
    input  strobe_t                  strobe,
    input  word_t                    wdata,
    output word_t                    rdata
);

    // every line of every way, laid out set by set
    word_t mem [SETS * WAYS * WORDS_PER_LINE];

    // byte lanes written only where the strobe is set
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (strobe[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // zero latency read, so a writeback beat sees its word in the same cycle
    assign rdata = mem[addr];

endmodule

// File: src/tag_array.sv
`timescale 1ns/1ps

module tag_array
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  addr_t           req_addr,
    input  logic            meta_write,
    input  way_t            meta_way,
    input  logic            meta_dirty,
    output logic            hit,
    output way_t            hit_way,
    output logic [WAYS-1:0] way_valid,
    output logic            sel_dirty,
    output tag_t            sel_tag
);

    cache_addr_u addr_u;
    meta_t       meta [SETS][WAYS];
    meta_t       sel_meta;

    assign addr_u.raw = req_addr;

    // only valid bits are cleared, tags and dirty bits stay as they were
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    meta[s][w].valid <= 1'b0;
                end
            end
        end else if (meta_write) begin
            meta[addr_u.fields.index][meta_way] <= '{
                valid: 1'b1,
                dirty: meta_dirty,
                tag:   addr_u.fields.tag
            };
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_valid[w] = meta[addr_u.fields.index][w].valid;
        end
    end

    // walk downwards so the lowest matching way is the one left standing
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (way_valid[w] && meta[addr_u.fields.index][w].tag == addr_u.fields.tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // victim info for the way the controller works on
    assign sel_meta  = meta[addr_u.fields.index][meta_way];
    assign sel_dirty = sel_meta.valid && sel_meta.dirty;
    assign sel_tag   = sel_meta.tag;

endmodule

// File: src/lru_tracker.sv
`timescale 1ns/1ps

module lru_tracker
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  addr_t           req_addr,
    input  logic [WAYS-1:0] way_valid,
    input  logic            touch,
    input  way_t            touch_way,
    output way_t            victim_way
);

    cache_addr_u addr_u;
    age_t        age [SETS][WAYS];
    age_t        eff_age [WAYS];

    assign addr_u.raw = req_addr;

    // an invalid way always looks oldest
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            eff_age[w] = way_valid[w] ? age[addr_u.fields.index][w] : '1;
        end
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin : pick_victim
        way_t best;
        best = '0;
        for (int w = 1; w < WAYS; w++) begin
            if (eff_age[w] > eff_age[best]) begin
                best = way_t'(w);
            end
        end
        victim_way = best;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age[s][w] <= '1;
                end
            end
        end else if (touch) begin
            for (int w = 0; w < WAYS; w++) begin
                if (way_t'(w) == touch_way) begin
                    age[addr_u.fields.index][w] <= '0;
                end else if (way_valid[w] && eff_age[w] < eff_age[touch_way]) begin
                    // cannot wrap, it stays below the touched age
                    age[addr_u.fields.index][w] <= eff_age[w] + age_t'(1);
                end
            end
        end
    end

endmodule

// File: src/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  addr_t                    req_addr,
    input  word_t                    req_wdata,
    input  strobe_t                  req_strobe,
    input  logic                     hit,
    input  way_t                     hit_way,
    input  way_t                     victim_way,
    input  logic                     sel_dirty,
    input  tag_t                     sel_tag,
    input  logic                     mem_ready,
    input  logic                     mem_last,
    input  word_t                    mem_rdata,
    input  word_t                    ram_rdata,
    output logic                     resp_data_ok,
    output word_t                    resp_data,
    output logic                     mem_valid,
    output logic                     mem_write,
    output addr_t                    mem_addr,
    output word_t                    mem_wdata,
    output logic                     meta_write,
    output way_t                     meta_way,
    output logic                     meta_dirty,
    output logic                     touch,
    output way_t                     touch_way,
    output logic                     ram_en,
    output logic [RAM_ADDR_BITS-1:0] ram_addr,
    output strobe_t                  ram_strobe,
    output word_t                    ram_wdata
);

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        ALLOCATE
    } state_t;

    state_t                 state;
    state_t                 state_nxt;
    logic [BEAT_BITS-1:0]   beat;
    logic [OFFSET_BITS-1:0] ram_word;
    way_t                   work_way;
    logic                   last_beat;
    cache_addr_u            req_u;
    cache_addr_u            line_u;

    assign req_u.raw = req_addr;
    assign last_beat = mem_ready && mem_last;

    // once the new tag is written the hit lookup points at the refilled way
    assign work_way = hit ? hit_way : victim_way;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    state_nxt = COMPARE;
                end
            end
            COMPARE: begin
                if (hit) begin
                    state_nxt = IDLE;
                end else if (sel_dirty) begin
                    state_nxt = WRITEBACK;
                end else begin
                    state_nxt = ALLOCATE;
                end
            end
            WRITEBACK: begin
                if (last_beat) begin
                    state_nxt = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (last_beat) begin
                    state_nxt = COMPARE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            state <= state_nxt;
            if (mem_valid && mem_ready) begin
                beat <= mem_last ? '0 : beat + 1'b1;
            end
        end
    end

    // cpu response
    assign resp_data_ok = (state == COMPARE) && hit;
    assign resp_data    = ram_rdata;
    assign touch        = resp_data_ok;
    assign touch_way    = hit_way;

    // dirty on a write hit, clean with the new tag before a refill
    assign meta_write = ((state == COMPARE) && hit && |req_strobe)
                      || ((state == COMPARE) && !hit && !sel_dirty)
                      || ((state == WRITEBACK) && last_beat);
    assign meta_way   = work_way;
    assign meta_dirty = (state == COMPARE) && hit;

    // line storage
    assign ram_word   = (state == COMPARE) ? req_u.fields.offset : beat;
    assign ram_addr   = {req_u.fields.index, work_way, ram_word};
    assign ram_en     = ((state == COMPARE) && hit) || ((state == ALLOCATE) && mem_ready);
    assign ram_strobe = (state == ALLOCATE) ? '1 : req_strobe;
    assign ram_wdata  = (state == ALLOCATE) ? mem_rdata : req_wdata;

    // line base address, old tag when writing back
    always_comb begin
        line_u.fields.tag      = (state == WRITEBACK) ? sel_tag : req_u.fields.tag;
        line_u.fields.index    = req_u.fields.index;
        line_u.fields.offset   = '0;
        line_u.fields.byte_off = '0;
    end

    assign mem_valid = (state == WRITEBACK) || (state == ALLOCATE);
    assign mem_write = (state == WRITEBACK);
    assign mem_addr  = line_u.raw;
    assign mem_wdata = ram_rdata;

endmodule

// File: src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    // cpu side
    input  logic    req_valid,
    input  addr_t   req_addr,
    input  word_t   req_wdata,
    input  strobe_t req_strobe,
    output logic    resp_data_ok,
    output word_t   resp_data,
    // memory side
    output logic    mem_valid,
    output logic    mem_write,
    output addr_t   mem_addr,
    output word_t   mem_wdata,
    input  logic    mem_ready,
    input  logic    mem_last,
    input  word_t   mem_rdata
);

    logic                     hit;
    way_t                     hit_way;
    way_t                     victim_way;
    logic [WAYS-1:0]          way_valid;
    logic                     sel_dirty;
    tag_t                     sel_tag;
    logic                     meta_write;
    way_t                     meta_way;
    logic                     meta_dirty;
    logic                     touch;
    way_t                     touch_way;
    logic                     ram_en;
    logic [RAM_ADDR_BITS-1:0] ram_addr;
    strobe_t                  ram_strobe;
    word_t                    ram_wdata;
    word_t                    ram_rdata;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_strobe   (req_strobe),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .sel_dirty    (sel_dirty),
        .sel_tag      (sel_tag),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata),
        .ram_rdata    (ram_rdata),
        .resp_data_ok (resp_data_ok),
        .resp_data    (resp_data),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .meta_write   (meta_write),
        .meta_way     (meta_way),
        .meta_dirty   (meta_dirty),
        .touch        (touch),
        .touch_way    (touch_way),
        .ram_en       (ram_en),
        .ram_addr     (ram_addr),
        .ram_strobe   (ram_strobe),
        .ram_wdata    (ram_wdata)
    );

    tag_array u_tags (
        .clk        (clk),
        .reset      (reset),
        .req_addr   (req_addr),
        .meta_write (meta_write),
        .meta_way   (meta_way),
        .meta_dirty (meta_dirty),
        .hit        (hit),
        .hit_way    (hit_way),
        .way_valid  (way_valid),
        .sel_dirty  (sel_dirty),
        .sel_tag    (sel_tag)
    );

    lru_tracker u_lru (
        .clk        (clk),
        .reset      (reset),
        .req_addr   (req_addr),
        .way_valid  (way_valid),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

    data_ram u_ram (
        .clk    (clk),
        .en     (ram_en),
        .addr   (ram_addr),
        .strobe (ram_strobe),
        .wdata  (ram_wdata),
        .rdata  (ram_rdata)
    );

endmodule

// File: testbench/dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions
    import bus_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  mem_valid,
    input logic  mem_write,
    input addr_t mem_addr,
    input logic  mem_ready,
    input logic  mem_last,
    input logic  resp_data_ok
);

    // a burst request stays put until its last beat
    property burst_held;
        @(posedge clk) disable iff (reset)
        mem_valid && !(mem_ready && mem_last)
            |=> mem_valid && $stable(mem_write) && $stable(mem_addr);
    endproperty

    // response is a single cycle pulse
    property resp_pulse;
        @(posedge clk) disable iff (reset)
        resp_data_ok |=> !resp_data_ok;
    endproperty

    burst_held_a: assert property (burst_held)
        else $error("memory request changed before the last beat");

    resp_pulse_a: assert property (resp_pulse)
        else $error("resp_data_ok held for more than one cycle");

endmodule

bind dcache_top dcache_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .mem_valid    (mem_valid),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_ready    (mem_ready),
    .mem_last     (mem_last),
    .resp_data_ok (resp_data_ok)
);

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
    import bus_pkg::*;
    import cache_pkg::*;
();

    localparam int NUM_TESTS  = 18;
    localparam int RESP_LIMIT = 400;
    localparam word_t FILL_KEY = 64'hc0de_5eed_0f0f_a5a5;

    typedef struct packed {
        logic    is_write;
        addr_t   addr;
        word_t   wdata;
        strobe_t strobe;
        logic    expect_miss;
        logic    expect_wb;
        addr_t   wb_addr;
    } entry_t;

    // is_write, addr, wdata, strobe, expect_miss, expect_wb, wb_addr
    entry_t stim [NUM_TESTS] = '{
        // cold miss in set 0 then hit, partial write and merged read
        '{1'b0, 64'h0000_0000_8000_0008, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0010, 64'h0, 8'h00, 1'b0, 1'b0, 64'h0},
        '{1'b1, 64'h0000_0000_8000_0018, 64'h1122_3344_5566_7788, 8'h0f, 1'b0, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0018, 64'h0, 8'h00, 1'b0, 1'b0, 64'h0},
        // five tags in set 1 with reads only
        '{1'b0, 64'h0000_0000_8000_0080, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0280, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0480, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0680, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0880, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0080, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        // set 0 filled up behind the dirty line
        '{1'b0, 64'h0000_0000_8000_0200, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0400, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0600, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0800, 64'h0, 8'h00, 1'b1, 1'b1, 64'h0000_0000_8000_0000},
        '{1'b0, 64'h0000_0000_8000_0018, 64'h0, 8'h00, 1'b1, 1'b0, 64'h0},
        '{1'b1, 64'h0000_0000_8000_0020, 64'hdead_beef_0bad_f00d, 8'hff, 1'b0, 1'b0, 64'h0},
        // write miss in set 2 then read back
        '{1'b1, 64'h0000_0000_8000_0108, 64'ha5a5_a5a5_5a5a_5a5a, 8'hf0, 1'b1, 1'b0, 64'h0},
        '{1'b0, 64'h0000_0000_8000_0108, 64'h0, 8'h00, 1'b0, 1'b0, 64'h0}
    };

    logic    clk = 1'b0;
    logic    reset;
    logic    req_valid;
    addr_t   req_addr;
    word_t   req_wdata;
    strobe_t req_strobe;
    logic    resp_data_ok;
    word_t   resp_data;
    logic    mem_valid;
    logic    mem_write;
    addr_t   mem_addr;
    word_t   mem_wdata;
    logic    mem_ready;
    logic    mem_last;
    word_t   mem_rdata;

    // memory model and expected contents keyed by word address
    word_t shadow_mem [addr_t];
    word_t exp_mem [addr_t];
    addr_t wb_log [$];
    addr_t exp_wb_log [$];

    logic        burst_active;
    logic        burst_write;
    addr_t       burst_word;
    int          beat_idx;
    logic        rd_seen;
    logic        wb_seen;
    addr_t       rd_seen_addr;
    addr_t       wb_seen_addr;
    logic [15:0] lfsr;

    // replacement model
    logic m_valid [SETS][WAYS];
    logic m_dirty [SETS][WAYS];
    tag_t m_tag [SETS][WAYS];
    int   m_age [SETS][WAYS];

    int errors = 0;
    int tests = 0;

    always #50 clk = ~clk;

    dcache_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_strobe   (req_strobe),
        .resp_data_ok (resp_data_ok),
        .resp_data    (resp_data),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata)
    );

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // galois step with the lsb before the shift as the output bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic word_t mem_word(input addr_t waddr);
        if (shadow_mem.exists(waddr)) begin
            return shadow_mem[waddr];
        end else begin
            return waddr ^ FILL_KEY;
        end
    endfunction

    function automatic word_t exp_word(input addr_t waddr);
        if (exp_mem.exists(waddr)) begin
            return exp_mem[waddr];
        end else begin
            return waddr ^ FILL_KEY;
        end
    endfunction

    function automatic addr_t line_base(input addr_t addr);
        cache_addr_u u;
        u.raw = addr;
        u.fields.offset = '0;
        u.fields.byte_off = '0;
        return u.raw;
    endfunction

    task automatic merge_write(input addr_t waddr, input word_t wdata, input strobe_t strobe);
        word_t w;
        w = exp_word(waddr);
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (strobe[b]) begin
                w[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        exp_mem[waddr] = w;
    endtask

    // one burst beat decided per falling edge and taken on the next rising edge
    task automatic serve_memory();
        logic  rdy;
        addr_t waddr;
        word_t wdata_now;
        wdata_now = mem_wdata;
        if (mem_valid === 1'b1) begin
            if (!burst_active) begin
                burst_active = 1'b1;
                burst_write = mem_write;
                burst_word = mem_addr >> 3;
                beat_idx = 0;
                if (mem_write) begin
                    wb_seen = 1'b1;
                    wb_seen_addr = mem_addr;
                    wb_log.push_back(mem_addr);
                end else begin
                    rd_seen = 1'b1;
                    rd_seen_addr = mem_addr;
                end
            end
            rdy = lfsr[0];
            lfsr = lfsr_next(lfsr);
            waddr = burst_word + addr_t'(beat_idx);
            if (rdy && burst_write) begin
                check_word("mem_wdata", wdata_now, exp_word(waddr));
                shadow_mem[waddr] = wdata_now;
            end
            mem_ready = rdy;
            mem_last = rdy && (beat_idx == BURST_LEN - 1);
            mem_rdata = burst_write ? '0 : mem_word(waddr);
            if (rdy) begin
                beat_idx++;
                if (beat_idx == BURST_LEN) begin
                    burst_active = 1'b0;
                end
            end
        end else begin
            mem_ready = 1'b0;
            mem_last = 1'b0;
        end
    endtask

    task automatic tick();
        @(negedge clk);
        serve_memory();
    endtask

    // every write burst of the run against the predicted victims
    task automatic verify_write_bursts();
        if (wb_log.size() != exp_wb_log.size()) begin
            $display("saw %0d write bursts but expected %0d", wb_log.size(),
                     exp_wb_log.size());
            errors++;
        end else begin
            foreach (wb_log[k]) begin
                check_addr("logged writeback mem_addr", wb_log[k], exp_wb_log[k]);
            end
        end
    endtask

    // hit lookup, victim choice and age update for one access
    task automatic model_access(input addr_t addr, input logic is_write, output logic miss,
                                output logic wb, output addr_t wb_addr);
        cache_addr_u a;
        cache_addr_u v;
        int s;
        int way;
        int eff [WAYS];
        a.raw = addr;
        s = int'(a.fields.index);
        way = -1;
        miss = 1'b0;
        wb = 1'b0;
        wb_addr = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (m_valid[s][w] && m_tag[s][w] == a.fields.tag) begin
                way = w;
            end
        end
        // invalid ways count as oldest
        for (int w = 0; w < WAYS; w++) begin
            eff[w] = m_valid[s][w] ? m_age[s][w] : WAYS - 1;
        end
        if (way < 0) begin
            miss = 1'b1;
            way = 0;
            for (int w = 1; w < WAYS; w++) begin
                if (eff[w] > eff[way]) begin
                    way = w;
                end
            end
            if (m_valid[s][way] && m_dirty[s][way]) begin
                wb = 1'b1;
                v.raw = '0;
                v.fields.tag = m_tag[s][way];
                v.fields.index = a.fields.index;
                wb_addr = v.raw;
            end
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = 1'b0;
            m_tag[s][way] = a.fields.tag;
            eff[way] = m_age[s][way];
        end
        for (int w = 0; w < WAYS; w++) begin
            if (w == way) begin
                m_age[s][w] = 0;
            end else if (m_valid[s][w] && eff[w] < eff[way]) begin
                m_age[s][w] = eff[w] + 1;
            end
        end
        if (is_write) begin
            m_dirty[s][way] = 1'b1;
        end
    endtask

    task automatic run_entry(input int i, output logic timed_out);
        logic  pred_miss;
        logic  pred_wb;
        logic  done;
        addr_t pred_wb_addr;
        addr_t waddr;
        word_t data;
        int    cycles;
        timed_out = 1'b0;
        waddr = stim[i].addr >> 3;
        model_access(stim[i].addr, stim[i].is_write, pred_miss, pred_wb, pred_wb_addr);
        if (pred_miss !== stim[i].expect_miss || pred_wb !== stim[i].expect_wb
                || (pred_wb && pred_wb_addr !== stim[i].wb_addr)) begin
            $display("test %0d: table entry disagrees with the replacement model", i);
            errors++;
        end
        if (pred_wb) begin
            exp_wb_log.push_back(pred_wb_addr);
        end
        rd_seen = 1'b0;
        wb_seen = 1'b0;
        tick();
        req_valid = 1'b1;
        req_addr = stim[i].addr;
        req_wdata = stim[i].wdata;
        req_strobe = stim[i].strobe;
        cycles = 0;
        done = 1'b0;
        data = '0;
        while (!done && cycles < RESP_LIMIT) begin
            tick();
            cycles++;
            if (resp_data_ok === 1'b1) begin
                done = 1'b1;
                data = resp_data;
            end
        end
        // held through the edge that takes the response
        tick();
        req_valid = 1'b0;
        req_strobe = '0;
        if (!done) begin
            $display("test %0d: no resp_data_ok within %0d cycles", i, RESP_LIMIT);
            timed_out = 1'b1;
        end else begin
            check_flag("read burst", rd_seen, pred_miss);
            check_flag("write burst", wb_seen, pred_wb);
            if (rd_seen) begin
                check_addr("refill mem_addr", rd_seen_addr, line_base(stim[i].addr));
            end
            if (pred_wb && wb_seen) begin
                check_addr("writeback mem_addr", wb_seen_addr, pred_wb_addr);
            end
            if (!pred_miss) begin
                check_flag("resp_data_ok one cycle after request", cycles == 1, 1'b1);
            end
            if (stim[i].is_write) begin
                merge_write(waddr, stim[i].wdata, stim[i].strobe);
            end else begin
                check_word("resp_data", data, exp_word(waddr));
            end
        end
    endtask

    initial begin : main
        logic timed_out;
        int   errs_before;
        reset = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_strobe = '0;
        mem_ready = 1'b0;
        mem_last = 1'b0;
        mem_rdata = '0;
        lfsr = 16'd37928;
        burst_active = 1'b0;
        burst_write = 1'b0;
        burst_word = '0;
        beat_idx = 0;
        timed_out = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w] = '0;
                m_age[s][w] = WAYS - 1;
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            errs_before = errors;
            run_entry(i, timed_out);
            tests++;
            if (errors == errs_before && !timed_out) begin
                $display("test %0d: addr %h write %0d ok", i, stim[i].addr, stim[i].is_write);
            end else begin
                $display("test %0d: addr %h write %0d failed", i, stim[i].addr, stim[i].is_write);
            end
        end
        if (!timed_out) begin
            verify_write_bursts();
        end
        $display("%0d tests, %0d errors, %0d write bursts", tests, errors, wb_log.size());
        if (!timed_out && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/bus_pkg.sv
src/cache_pkg.sv
src/data_ram.sv
src/tag_array.sv
src/lru_tracker.sv
src/cache_ctrl.sv
src/dcache_top.sv
testbench/dcache_assertions.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache -f vlog.f -o sim_dcache

# a failing assertion stops the run early, the search below then fails it
out=$(./obj_dir/sim_dcache 2>&1) || true
echo "$out"

if echo "$out" | grep -qxF '>>> PASS'; then
    exit 0
fi
exit 1
